// File: logic/rv32_mem_pkg.sv
package rv32_mem_pkg;

    // Data path and register file geometry
    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;
    localparam int FUNCT3_W = 3;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;

    // Byte position inside a word
    typedef logic [1:0] byte_off_t;

    typedef enum logic {
        load  = 1'b0,
        store = 1'b1
    } mem_op_e;

    // Load encodings from the RV32I base ISA
    typedef enum logic [FUNCT3_W-1:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // Store encodings, same field position as loads
    typedef enum logic [FUNCT3_W-1:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

endpackage

// File: logic/wb_bus_pkg.sv
package wb_bus_pkg;

    // Bus is 32 bits wide with byte lanes
    localparam int WB_SEL_W = 4;

    // Word addressing, byte address bits 1:0 are implied by select
    localparam int WB_ADR_W = 30;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // Select patterns before they are shifted to the byte offset
    localparam wb_sel_t SEL_BYTE = 4'b0001;
    localparam wb_sel_t SEL_HALF = 4'b0011;
    localparam wb_sel_t SEL_WORD = 4'b1111;

endpackage

// File: logic/lsu_request_decode.sv
`timescale 1ns/100ps

module lsu_request_decode (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_cmd_valid,
    output logic                    o_cmd_ready,
    input  rv32_mem_pkg::mem_op_e   i_cmd_op,
    input  rv32_mem_pkg::funct3_t   i_cmd_funct3,
    input  rv32_mem_pkg::word_t     i_cmd_addr,
    input  rv32_mem_pkg::word_t     i_cmd_wdata,
    input  rv32_mem_pkg::reg_idx_t  i_cmd_rd,
    input  logic                    i_full,
    output logic                    o_push,
    output wb_bus_pkg::wb_adr_t     o_adr,
    output wb_bus_pkg::wb_sel_t     o_sel,
    output logic                    o_we,
    output rv32_mem_pkg::word_t     o_dat,
    output rv32_mem_pkg::reg_idx_t  o_rd,
    output rv32_mem_pkg::funct3_t   o_funct3,
    output rv32_mem_pkg::byte_off_t o_off,
    output logic                    o_trap
);
    import rv32_mem_pkg::*;
    import wb_bus_pkg::*;

    byte_off_t off_d;
    wb_sel_t   sel_d;
    word_t     dat_d;
    logic      trap_d;
    logic      r_valid;
    logic      accept;

    assign off_d = i_cmd_addr[1:0];

    // Output register drains into the queue whenever there is room
    assign o_push = r_valid && !i_full;
    assign o_cmd_ready = !r_valid || !i_full;
    assign accept = i_cmd_valid && o_cmd_ready;

    // Byte enables and trap check by access size and offset
    always_comb begin
        sel_d = '0;
        dat_d = '0;
        trap_d = 1'b0;
        if (i_cmd_op == load) begin
            case (load_funct3_e'(i_cmd_funct3))
                lb, lbu: sel_d = SEL_BYTE << off_d;
                lh, lhu: begin
                    if (off_d[0]) begin
                        trap_d = 1'b1;
                    end else begin
                        sel_d = SEL_HALF << off_d;
                    end
                end
                lw: begin
                    if (off_d != 2'b00) begin
                        trap_d = 1'b1;
                    end else begin
                        sel_d = SEL_WORD;
                    end
                end
                default: trap_d = 1'b1;
            endcase
        end else begin
            case (store_funct3_e'(i_cmd_funct3))
                sb: begin
                    sel_d = SEL_BYTE << off_d;
                    dat_d = i_cmd_wdata << {off_d, 3'b000};
                end
                sh: begin
                    if (off_d[0]) begin
                        trap_d = 1'b1;
                    end else begin
                        sel_d = SEL_HALF << off_d;
                        dat_d = i_cmd_wdata << {off_d, 3'b000};
                    end
                end
                sw: begin
                    if (off_d != 2'b00) begin
                        trap_d = 1'b1;
                    end else begin
                        sel_d = SEL_WORD;
                        dat_d = i_cmd_wdata;
                    end
                end
                default: trap_d = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_valid <= 1'b0;
        end else if (accept) begin
            r_valid <= 1'b1;
        end else if (o_push) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_adr <= i_cmd_addr[31:2];
            o_sel <= sel_d;
            o_we <= (i_cmd_op == store);
            o_dat <= dat_d;
            o_rd <= i_cmd_rd;
            o_funct3 <= i_cmd_funct3;
            o_off <= off_d;
            o_trap <= trap_d;
        end
    end

endmodule

// File: logic/lsu_request_fifo.sv
`timescale 1ns/100ps

module lsu_request_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_push,
    input  logic                    i_pop,
    output logic                    o_full,
    output logic                    o_empty,
    input  wb_bus_pkg::wb_adr_t     i_adr,
    input  wb_bus_pkg::wb_sel_t     i_sel,
    input  logic                    i_we,
    input  rv32_mem_pkg::word_t     i_dat,
    input  rv32_mem_pkg::reg_idx_t  i_rd,
    input  rv32_mem_pkg::funct3_t   i_funct3,
    input  rv32_mem_pkg::byte_off_t i_off,
    input  logic                    i_trap,
    output wb_bus_pkg::wb_adr_t     o_adr,
    output wb_bus_pkg::wb_sel_t     o_sel,
    output logic                    o_we,
    output rv32_mem_pkg::word_t     o_dat,
    output rv32_mem_pkg::reg_idx_t  o_rd,
    output rv32_mem_pkg::funct3_t   o_funct3,
    output rv32_mem_pkg::byte_off_t o_off,
    output logic                    o_trap
);
    import rv32_mem_pkg::*;
    import wb_bus_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // One flat entry holds every request field
    localparam int ENTRY_W = $bits(wb_adr_t) + $bits(wb_sel_t) + 1 + $bits(word_t)
                           + $bits(reg_idx_t) + $bits(funct3_t) + $bits(byte_off_t) + 1;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] wr_entry;
    logic [PTR_W:0]     wr_ptr;
    logic [PTR_W:0]     rd_ptr;
    logic               wr_en;
    logic               rd_en;

    // Wrap bit differs only when the write side is a full lap ahead
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                 && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_en = i_push && !o_full;
    assign rd_en = i_pop && !o_empty;

    assign wr_entry = {i_adr, i_sel, i_we, i_dat, i_rd, i_funct3, i_off, i_trap};

    // Head entry straight from the array
    assign {o_adr, o_sel, o_we, o_dat, o_rd, o_funct3, o_off, o_trap} =
        mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: logic/lsu_wb_master.sv
`timescale 1ns/100ps

module lsu_wb_master (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_empty,
    output logic                    o_pop,
    input  wb_bus_pkg::wb_adr_t     i_adr,
    input  wb_bus_pkg::wb_sel_t     i_sel,
    input  logic                    i_we,
    input  rv32_mem_pkg::word_t     i_dat,
    input  rv32_mem_pkg::reg_idx_t  i_rd,
    input  rv32_mem_pkg::funct3_t   i_funct3,
    input  rv32_mem_pkg::byte_off_t i_off,
    input  logic                    i_trap,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic                    o_wb_we,
    output wb_bus_pkg::wb_adr_t     o_wb_adr,
    output rv32_mem_pkg::word_t     o_wb_dat,
    output wb_bus_pkg::wb_sel_t     o_wb_sel,
    input  rv32_mem_pkg::word_t     i_wb_dat,
    input  logic                    i_wb_ack,
    output logic                    o_rsp_valid,
    output rv32_mem_pkg::word_t     o_rsp_data,
    output rv32_mem_pkg::reg_idx_t  o_rsp_rd,
    output logic                    o_rsp_trap
);
    import rv32_mem_pkg::*;
    import wb_bus_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_bus,
        s_respond
    } state_e;

    state_e    state;
    state_e    state_next;
    wb_adr_t   r_adr;
    wb_sel_t   r_sel;
    logic      r_we;
    word_t     r_dat;
    reg_idx_t  r_rd;
    funct3_t   r_funct3;
    byte_off_t r_off;
    logic      r_trap;
    word_t     r_rsp_data;
    word_t     lane_data;
    word_t     ld_data;

    assign o_pop = (state == s_idle) && !i_empty;

    // Bus signals held steady from the latched entry
    assign o_wb_cyc = (state == s_bus);
    assign o_wb_stb = (state == s_bus);
    assign o_wb_we = (state == s_bus) && r_we;
    assign o_wb_adr = r_adr;
    assign o_wb_dat = r_dat;
    assign o_wb_sel = r_sel;

    assign o_rsp_valid = (state == s_respond);
    assign o_rsp_data = r_rsp_data;
    assign o_rsp_rd = r_rd;
    assign o_rsp_trap = r_trap;

    // Addressed byte moved down to lane 0, then extended by load type
    assign lane_data = i_wb_dat >> {r_off, 3'b000};

    always_comb begin
        case (load_funct3_e'(r_funct3))
            lb:      ld_data = {{24{lane_data[7]}}, lane_data[7:0]};
            lbu:     ld_data = {24'b0, lane_data[7:0]};
            lh:      ld_data = {{16{lane_data[15]}}, lane_data[15:0]};
            lhu:     ld_data = {16'b0, lane_data[15:0]};
            lw:      ld_data = i_wb_dat;
            default: ld_data = '0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (!i_empty) begin
                    // Trapped entries skip the bus entirely
                    state_next = i_trap ? s_respond : s_bus;
                end
            end
            s_bus: begin
                if (i_wb_ack) begin
                    state_next = s_respond;
                end
            end
            s_respond: state_next = s_idle;
            default:   state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            r_adr <= i_adr;
            r_sel <= i_sel;
            r_we <= i_we;
            r_dat <= i_dat;
            r_rd <= i_rd;
            r_funct3 <= i_funct3;
            r_off <= i_off;
            r_trap <= i_trap;
            // Zero unless a load completes
            r_rsp_data <= '0;
        end else if ((state == s_bus) && i_wb_ack && !r_we) begin
            r_rsp_data <= ld_data;
        end
    end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_cmd_valid,
    output logic                   o_cmd_ready,
    input  rv32_mem_pkg::mem_op_e  i_cmd_op,
    input  rv32_mem_pkg::funct3_t  i_cmd_funct3,
    input  rv32_mem_pkg::word_t    i_cmd_addr,
    input  rv32_mem_pkg::word_t    i_cmd_wdata,
    input  rv32_mem_pkg::reg_idx_t i_cmd_rd,
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic                   o_wb_we,
    output wb_bus_pkg::wb_adr_t    o_wb_adr,
    output rv32_mem_pkg::word_t    o_wb_dat,
    output wb_bus_pkg::wb_sel_t    o_wb_sel,
    input  rv32_mem_pkg::word_t    i_wb_dat,
    input  logic                   i_wb_ack,
    output logic                   o_rsp_valid,
    output rv32_mem_pkg::word_t    o_rsp_data,
    output rv32_mem_pkg::reg_idx_t o_rsp_rd,
    output logic                   o_rsp_trap
);
    import rv32_mem_pkg::*;
    import wb_bus_pkg::*;

    // Decoder to queue
    logic      dec_push;
    logic      fifo_full;
    wb_adr_t   dec_adr;
    wb_sel_t   dec_sel;
    logic      dec_we;
    word_t     dec_dat;
    reg_idx_t  dec_rd;
    funct3_t   dec_funct3;
    byte_off_t dec_off;
    logic      dec_trap;

    // Queue head to bus master
    logic      fifo_empty;
    logic      mst_pop;
    wb_adr_t   head_adr;
    wb_sel_t   head_sel;
    logic      head_we;
    word_t     head_dat;
    reg_idx_t  head_rd;
    funct3_t   head_funct3;
    byte_off_t head_off;
    logic      head_trap;

    lsu_request_decode u_decode (
        .clk(clk), .i_rst(i_rst),
        .i_cmd_valid(i_cmd_valid), .o_cmd_ready(o_cmd_ready),
        .i_cmd_op(i_cmd_op), .i_cmd_funct3(i_cmd_funct3),
        .i_cmd_addr(i_cmd_addr), .i_cmd_wdata(i_cmd_wdata), .i_cmd_rd(i_cmd_rd),
        .i_full(fifo_full), .o_push(dec_push),
        .o_adr(dec_adr), .o_sel(dec_sel), .o_we(dec_we), .o_dat(dec_dat),
        .o_rd(dec_rd), .o_funct3(dec_funct3), .o_off(dec_off), .o_trap(dec_trap)
    );

    lsu_request_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk(clk), .i_rst(i_rst),
        .i_push(dec_push), .i_pop(mst_pop), .o_full(fifo_full), .o_empty(fifo_empty),
        .i_adr(dec_adr), .i_sel(dec_sel), .i_we(dec_we), .i_dat(dec_dat),
        .i_rd(dec_rd), .i_funct3(dec_funct3), .i_off(dec_off), .i_trap(dec_trap),
        .o_adr(head_adr), .o_sel(head_sel), .o_we(head_we), .o_dat(head_dat),
        .o_rd(head_rd), .o_funct3(head_funct3), .o_off(head_off), .o_trap(head_trap)
    );

    lsu_wb_master u_master (
        .clk(clk), .i_rst(i_rst),
        .i_empty(fifo_empty), .o_pop(mst_pop),
        .i_adr(head_adr), .i_sel(head_sel), .i_we(head_we), .i_dat(head_dat),
        .i_rd(head_rd), .i_funct3(head_funct3), .i_off(head_off), .i_trap(head_trap),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_sel(o_wb_sel),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack),
        .o_rsp_valid(o_rsp_valid), .o_rsp_data(o_rsp_data),
        .o_rsp_rd(o_rsp_rd), .o_rsp_trap(o_rsp_trap)
    );

endmodule

// File: sim/wb_slave_model.sv
`timescale 1ns/100ps

module wb_slave_model #(
    parameter int MEM_WORDS = 16,
    parameter int SEED = 1
) (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_cyc,
    input  logic                i_stb,
    input  logic                i_we,
    input  wb_bus_pkg::wb_adr_t i_adr,
    input  rv32_mem_pkg::word_t i_dat,
    input  wb_bus_pkg::wb_sel_t i_sel,
    output rv32_mem_pkg::word_t o_dat,
    output logic                o_ack
);
    import rv32_mem_pkg::*;

    localparam int ADR_W = $clog2(MEM_WORDS);

    word_t      mem [MEM_WORDS];
    integer     seed;
    integer     rnd;
    logic [1:0] delay;
    logic [1:0] wait_cnt;

    // Word i starts as i * 0x01010101 + 0x80402010
    initial begin
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i * 32'h0101_0101 + 32'h8040_2010;
        end
    end

    assign o_dat = mem[i_adr[ADR_W-1:0]];

    always @(posedge clk) begin
        if (i_rst) begin
            o_ack <= 1'b0;
            wait_cnt <= '0;
            delay <= '0;
        end else if (o_ack) begin
            // Master samples ack on this edge, write lanes and draw the next delay
            o_ack <= 1'b0;
            wait_cnt <= '0;
            rnd = $random(seed);
            delay <= rnd[1:0];
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_sel[b]) begin
                        mem[i_adr[ADR_W-1:0]][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                end
            end
        end else if (i_cyc && i_stb) begin
            if (wait_cnt == delay) begin
                o_ack <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

// File: sim/lsu_tb.sv
`timescale 1ns/100ps

module lsu_tb;
    import rv32_mem_pkg::*;
    import wb_bus_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_ROWS = 38;
    localparam int SEED = 61806;
    localparam int MEM_WORDS = 16;

    logic     clk;
    logic     rst;
    logic     cmd_valid;
    logic     cmd_ready;
    mem_op_e  cmd_op;
    funct3_t  cmd_funct3;
    word_t    cmd_addr;
    word_t    cmd_wdata;
    reg_idx_t cmd_rd;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    word_t    wb_dat_w;
    word_t    wb_dat_r;
    wb_sel_t  wb_sel;
    logic     wb_ack;
    logic     rsp_valid;
    word_t    rsp_data;
    reg_idx_t rsp_rd;
    logic     rsp_trap;

    // One stimulus and expected response entry per command
    string    row_name [N_ROWS];
    mem_op_e  row_op [N_ROWS];
    funct3_t  row_f3 [N_ROWS];
    word_t    row_addr [N_ROWS];
    word_t    row_wdata [N_ROWS];
    reg_idx_t row_rd [N_ROWS];
    word_t    row_exp [N_ROWS];
    logic     row_trap [N_ROWS];
    int       n_rows;
    int       expect_q [$];
    int       n_checked;
    int       n_bus;
    bit       saw_stall;

    // Bus request seen at the previous falling edge
    bit       held_cyc;
    bit       held_ack;
    logic     held_we;
    wb_adr_t  held_adr;
    word_t    held_dat;
    wb_sel_t  held_sel;

    lsu_top u_lsu_top (
        .clk(clk), .i_rst(rst),
        .i_cmd_valid(cmd_valid), .o_cmd_ready(cmd_ready), .i_cmd_op(cmd_op),
        .i_cmd_funct3(cmd_funct3), .i_cmd_addr(cmd_addr), .i_cmd_wdata(cmd_wdata),
        .i_cmd_rd(cmd_rd),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_adr(wb_adr),
        .o_wb_dat(wb_dat_w), .o_wb_sel(wb_sel), .i_wb_dat(wb_dat_r), .i_wb_ack(wb_ack),
        .o_rsp_valid(rsp_valid), .o_rsp_data(rsp_data), .o_rsp_rd(rsp_rd),
        .o_rsp_trap(rsp_trap)
    );

    wb_slave_model #(
        .MEM_WORDS(MEM_WORDS),
        .SEED(SEED)
    ) u_slave (
        .clk(clk), .i_rst(rst), .i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we),
        .i_adr(wb_adr), .i_dat(wb_dat_w), .i_sel(wb_sel), .o_dat(wb_dat_r), .o_ack(wb_ack)
    );

    task automatic report_mismatch(input string name, input string field,
                                   input word_t exp, input word_t act);
        $display("Mismatch in %s: %s expected %h, actual %h", name, field, exp, act);
        $display("tests failed");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
    endtask

    task automatic add_row(input string name, input mem_op_e op, input funct3_t f3,
                           input word_t addr, input word_t wdata, input reg_idx_t rd,
                           input word_t exp, input logic trap);
        row_name[n_rows] = name;
        row_op[n_rows] = op;
        row_f3[n_rows] = f3;
        row_addr[n_rows] = addr;
        row_wdata[n_rows] = wdata;
        row_rd[n_rows] = rd;
        row_exp[n_rows] = exp;
        row_trap[n_rows] = trap;
        n_rows++;
    endtask

    // Expected data follows the initial memory rule and the merged store lanes
    task automatic build_table();
        add_row("lw_word1", load, lw, 32'h04, 32'h0, 5'd1, 32'h8141_2111, 1'b0);
        add_row("lw_word5", load, lw, 32'h14, 32'h0, 5'd2, 32'h8545_2515, 1'b0);
        add_row("lh_word2_off0", load, lh, 32'h08, 32'h0, 5'd3, 32'h0000_2212, 1'b0);
        add_row("lh_word2_off2", load, lh, 32'h0A, 32'h0, 5'd4, 32'hFFFF_8242, 1'b0);
        add_row("lhu_word2_off2", load, lhu, 32'h0A, 32'h0, 5'd5, 32'h0000_8242, 1'b0);
        add_row("lhu_word3_off0", load, lhu, 32'h0C, 32'h0, 5'd6, 32'h0000_2313, 1'b0);
        add_row("lb_off0", load, lb, 32'h18, 32'h0, 5'd7, 32'h0000_0016, 1'b0);
        add_row("lb_off1", load, lb, 32'h19, 32'h0, 5'd8, 32'h0000_0026, 1'b0);
        add_row("lb_off2", load, lb, 32'h1A, 32'h0, 5'd9, 32'h0000_0046, 1'b0);
        add_row("lb_off3", load, lb, 32'h1B, 32'h0, 5'd10, 32'hFFFF_FF86, 1'b0);
        add_row("lbu_off0", load, lbu, 32'h1C, 32'h0, 5'd11, 32'h0000_0017, 1'b0);
        add_row("lbu_off1", load, lbu, 32'h1D, 32'h0, 5'd12, 32'h0000_0027, 1'b0);
        add_row("lbu_off2", load, lbu, 32'h1E, 32'h0, 5'd13, 32'h0000_0047, 1'b0);
        add_row("lbu_off3", load, lbu, 32'h1F, 32'h0, 5'd14, 32'h0000_0087, 1'b0);
        add_row("sb_word8_off1", store, sb, 32'h21, 32'h0000_00A5, 5'd15, 32'h0, 1'b0);
        add_row("lw_after_sb", load, lw, 32'h20, 32'h0, 5'd16, 32'h8848_A518, 1'b0);
        add_row("sh_word9_off2", store, sh, 32'h26, 32'h0000_C3D4, 5'd17, 32'h0, 1'b0);
        add_row("lw_after_sh", load, lw, 32'h24, 32'h0, 5'd18, 32'hC3D4_2919, 1'b0);
        add_row("sw_word10", store, sw, 32'h28, 32'hDEAD_BEEF, 5'd19, 32'h0, 1'b0);
        add_row("lw_after_sw", load, lw, 32'h28, 32'h0, 5'd20, 32'hDEAD_BEEF, 1'b0);
        add_row("sb_word10_off3", store, sb, 32'h2B, 32'h1234_5677, 5'd21, 32'h0, 1'b0);
        add_row("lh_after_sb", load, lh, 32'h2A, 32'h0, 5'd22, 32'h0000_77AD, 1'b0);
        add_row("sh_word9_off0", store, sh, 32'h24, 32'hFFFF_0102, 5'd23, 32'h0, 1'b0);
        add_row("lw_after_sh_low", load, lw, 32'h24, 32'h0, 5'd24, 32'hC3D4_0102, 1'b0);
        add_row("lw_misaligned", load, lw, 32'h2D, 32'h0, 5'd25, 32'h0, 1'b1);
        add_row("sw_misaligned", store, sw, 32'h2E, 32'h1111_1111, 5'd26, 32'h0, 1'b1);
        add_row("sh_odd_offset", store, sh, 32'h2F, 32'h0000_2222, 5'd27, 32'h0, 1'b1);
        add_row("lh_odd_offset", load, lh, 32'h31, 32'h0, 5'd28, 32'h0, 1'b1);
        add_row("lhu_odd_offset", load, lhu, 32'h33, 32'h0, 5'd29, 32'h0, 1'b1);
        add_row("lw_word11_kept", load, lw, 32'h2C, 32'h0, 5'd30, 32'h8B4B_2B1B, 1'b0);
        add_row("store_bad_funct3", store, 3'b011, 32'h30, 32'hFFFF_FFFF, 5'd31, 32'h0, 1'b1);
        add_row("load_bad_funct3", load, 3'b111, 32'h30, 32'h0, 5'd1, 32'h0, 1'b1);
        add_row("lw_word12_kept", load, lw, 32'h30, 32'h0, 5'd2, 32'h8C4C_2C1C, 1'b0);
        add_row("burst_word13", load, lw, 32'h34, 32'h0, 5'd3, 32'h8D4D_2D1D, 1'b0);
        add_row("burst_word14", load, lw, 32'h38, 32'h0, 5'd4, 32'h8E4E_2E1E, 1'b0);
        add_row("burst_word15", load, lw, 32'h3C, 32'h0, 5'd5, 32'h8F4F_2F1F, 1'b0);
        add_row("burst_word0", load, lw, 32'h00, 32'h0, 5'd6, 32'h8040_2010, 1'b0);
        add_row("burst_word4", load, lw, 32'h10, 32'h0, 5'd7, 32'h8444_2414, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_ROWS * 20 * CLK_PERIOD);
        report_failure($sformatf("Timeout with %0d of %0d responses checked",
                                 n_checked, N_ROWS));
        $fatal(1);
    end

    // Bus activity and back-pressure sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && !cmd_ready) begin
            saw_stall = 1'b1;
        end
        if (wb_cyc && wb_ack) begin
            n_bus++;
        end
        assert (wb_stb == wb_cyc) else begin
            report_failure("Bus strobe and cycle differ");
            $fatal(1);
        end
        // Request holds steady until the slave acknowledges
        if (held_cyc && !held_ack) begin
            assert (wb_cyc && wb_we == held_we && wb_adr == held_adr
                    && wb_dat_w == held_dat && wb_sel == held_sel) else begin
                report_failure("Bus request changed or dropped before acknowledge");
                $fatal(1);
            end
        end
        if (held_cyc && held_ack) begin
            assert (!wb_cyc) else begin
                report_failure("Bus cycle still open after acknowledge");
                $fatal(1);
            end
        end
        held_cyc = wb_cyc;
        held_ack = wb_ack;
        held_we = wb_we;
        held_adr = wb_adr;
        held_dat = wb_dat_w;
        held_sel = wb_sel;
    end

    // Responses must come back in command order
    always @(negedge clk) begin
        int idx;
        if (rsp_valid) begin
            assert (expect_q.size() > 0) else begin
                report_failure("Response arrived with no command outstanding");
                $fatal(1);
            end
            idx = expect_q.pop_front();
            assert (rsp_rd == row_rd[idx]) else begin
                report_mismatch(row_name[idx], "rd", row_rd[idx], rsp_rd);
                $fatal(1);
            end
            assert (rsp_trap == row_trap[idx]) else begin
                report_mismatch(row_name[idx], "trap", row_trap[idx], rsp_trap);
                $fatal(1);
            end
            assert (rsp_data == row_exp[idx]) else begin
                report_mismatch(row_name[idx], "data", row_exp[idx], rsp_data);
                $fatal(1);
            end
            n_checked++;
        end
    end

    initial begin
        int  idx;
        int  exp_bus;
        bit  accepted;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = load;
        cmd_funct3 = '0;
        cmd_addr = '0;
        cmd_wdata = '0;
        cmd_rd = '0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (cmd_ready && !wb_cyc && !wb_stb && !wb_we && !rsp_valid) else begin
            report_failure("Outputs not idle after reset");
            $fatal(1);
        end
        @(posedge clk);
        #1;
        for (idx = 0; idx < N_ROWS; idx++) begin
            cmd_valid = 1'b1;
            cmd_op = row_op[idx];
            cmd_funct3 = row_f3[idx];
            cmd_addr = row_addr[idx];
            cmd_wdata = row_wdata[idx];
            cmd_rd = row_rd[idx];
            accepted = 1'b0;
            // Ready seen before the edge means the edge takes the command
            while (!accepted) begin
                @(negedge clk);
                if (cmd_ready) begin
                    accepted = 1'b1;
                    expect_q.push_back(idx);
                end
                @(posedge clk);
                #1;
            end
        end
        cmd_valid = 1'b0;
        wait (n_checked == N_ROWS);
        @(negedge clk);
        exp_bus = 0;
        for (idx = 0; idx < N_ROWS; idx++) begin
            if (!row_trap[idx]) begin
                exp_bus++;
            end
        end
        // Trapped requests must not have produced a bus cycle
        assert (n_bus == exp_bus) else begin
            report_mismatch("bus_cycle_count", "count", exp_bus, n_bus);
            $fatal(1);
        end
        assert (saw_stall) else begin
            report_failure("Command ready never dropped under back-pressure");
            $fatal(1);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: sources.f
logic/rv32_mem_pkg.sv
logic/wb_bus_pkg.sv
logic/lsu_request_decode.sv
logic/lsu_request_fifo.sv
logic/lsu_wb_master.sv
logic/lsu_top.sv
sim/wb_slave_model.sv
sim/lsu_tb.sv
